/* logic/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// the line holds this many words and a column vector has one bit per word.
`define DC_LINE_WORDS 16
// each word has this many bits and so this many addressable columns.
`define DC_WORD_BITS 16
// word address width on the command side.
`define DC_ADDR_BITS 16
// byte address width on the DDR side.
`define DC_DDR_ADDR_BITS 28
// one word occupies 8 bytes of DDR.
`define DC_DDR_ADDR_SHIFT 3

`define DC_ROW_IDX_BITS ($clog2(`DC_LINE_WORDS))
`define DC_COL_IDX_BITS ($clog2(`DC_WORD_BITS))

`endif

/* logic/cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

    typedef enum logic [2:0] {
        CMD_NONE      = 3'd0,
        CMD_ROW_LOAD  = 3'd1,
        CMD_ROW_STORE = 3'd2,
        CMD_COL_LOAD  = 3'd3,
        CMD_COL_STORE = 3'd4,
        CMD_FLUSH     = 3'd5
    } cmd_t;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_WRITEBACK = 3'd1,
        ST_FILL      = 3'd2,
        ST_ACCESS    = 3'd3
    } ctrl_state_t;

    typedef logic [`DC_WORD_BITS-1:0]  word_t;
    typedef logic [`DC_LINE_WORDS-1:0] col_t;  // bit i belongs to word i.

endpackage

/* logic/line_if.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

interface line_if;

    logic [`DC_ROW_IDX_BITS-1:0] row_idx;
    logic [`DC_WORD_BITS-1:0]    row_wdata;
    logic                        row_we;
    logic [`DC_COL_IDX_BITS-1:0] col_idx;
    logic [`DC_LINE_WORDS-1:0]   col_wdata;
    logic                        col_we;
    logic                        engine_sel;     // engine owns the row port during a burst.

    logic [`DC_ROW_IDX_BITS-1:0] eng_row_idx;
    logic [`DC_WORD_BITS-1:0]    eng_row_wdata;
    logic                        eng_row_we;

    logic [`DC_WORD_BITS-1:0]    row_rdata;
    logic [`DC_LINE_WORDS-1:0]   col_rdata;

    modport ctrl_mp (output row_idx, row_wdata, row_we, col_idx, col_wdata, col_we,
                     output engine_sel, input row_rdata, col_rdata);

    modport engine_mp (output eng_row_idx, eng_row_wdata, eng_row_we, input row_rdata);

    modport store_mp (input row_idx, row_wdata, row_we, col_idx, col_wdata, col_we,
                      input engine_sel, eng_row_idx, eng_row_wdata, eng_row_we,
                      output row_rdata, col_rdata);

endinterface

/* logic/line_store.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module line_store
    import cache_pkg::*;
(
    input logic     clk,
    line_if.store_mp lif
);

    word_t                       mem [`DC_LINE_WORDS];
    logic [`DC_ROW_IDX_BITS-1:0] sel_idx;
    word_t                       sel_wdata;
    logic                        sel_we;
    col_t                        col_gather;

    // ***********************************************************************
    // row port owner
    // ***********************************************************************

    always_comb begin
        if (lif.engine_sel) begin
            sel_idx   = lif.eng_row_idx;
            sel_wdata = lif.eng_row_wdata;
            sel_we    = lif.eng_row_we;
        end else begin
            sel_idx   = lif.row_idx;
            sel_wdata = lif.row_wdata;
            sel_we    = lif.row_we;
        end
    end

    // ***********************************************************************
    // array update
    // ***********************************************************************

    always_ff @(posedge clk) begin
        if (sel_we) begin
            mem[sel_idx] <= sel_wdata;
        end else if (lif.col_we && !lif.engine_sel) begin
            for (int i = 0; i < `DC_LINE_WORDS; i++) begin
                mem[i][lif.col_idx] <= lif.col_wdata[i];   // one bit in every word.
            end
        end
    end

    // reads see the array as of the last edge.
    assign lif.row_rdata = mem[sel_idx];

    always_comb begin
        for (int i = 0; i < `DC_LINE_WORDS; i++) begin
            col_gather[i] = mem[i][lif.col_idx];
        end
    end

    assign lif.col_rdata = col_gather;

endmodule

/* logic/ddr_burst_engine.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module ddr_burst_engine
    import cache_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fill_start,
    input  logic                         wb_start,
    input  logic [`DC_ADDR_BITS-1:0]     line_base,
    input  logic [`DC_ADDR_BITS-1:0]     wb_base,
    input  logic                         ddr_rd_valid,
    input  word_t                        ddr_rd_data,
    output logic                         ddr_rd_req,
    output logic [`DC_DDR_ADDR_BITS-1:0] ddr_rd_addr,
    output logic                         ddr_wr_req,
    output logic [`DC_DDR_ADDR_BITS-1:0] ddr_wr_addr,
    output logic                         ddr_wr_valid,
    output word_t                        ddr_wr_data,
    output logic                         burst_done,
    line_if.engine_mp                    lif
);

    localparam int CNT_BITS = `DC_ROW_IDX_BITS + 1;
    localparam int PAD_BITS = `DC_DDR_ADDR_BITS - `DC_ADDR_BITS - `DC_DDR_ADDR_SHIFT;
    localparam logic [CNT_BITS-1:0] LAST = CNT_BITS'(`DC_LINE_WORDS);

    logic [CNT_BITS-1:0] cnt;
    logic [CNT_BITS-1:0] cnt_inc;
    logic                fill_run;
    logic                wb_run;
    logic                fill_go;
    logic                wb_go;
    logic                rd_take;
    logic                wr_send;

    assign fill_go = fill_start | fill_run;
    assign wb_go   = wb_start | wb_run;
    assign rd_take = fill_go & ddr_rd_valid;
    assign wr_send = wb_go & (cnt != LAST);  // stop putting words out after the 16th.
    assign cnt_inc = cnt + CNT_BITS'(1);

    assign ddr_rd_req  = fill_start;
    assign ddr_wr_req  = wb_start;
    assign ddr_rd_addr = {{PAD_BITS{1'b0}}, line_base, {`DC_DDR_ADDR_SHIFT{1'b0}}};
    assign ddr_wr_addr = {{PAD_BITS{1'b0}}, wb_base, {`DC_DDR_ADDR_SHIFT{1'b0}}};

    // fill words go straight into the line at the running index.
    assign lif.eng_row_idx   = cnt[`DC_ROW_IDX_BITS-1:0];
    assign lif.eng_row_wdata = ddr_rd_data;
    assign lif.eng_row_we    = rd_take;

    // ***********************************************************************
    // burst counter
    // ***********************************************************************

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt          <= '0;
            fill_run     <= 1'b0;
            wb_run       <= 1'b0;
            ddr_wr_valid <= 1'b0;
            burst_done   <= 1'b0;
        end else begin
            burst_done   <= 1'b0;
            ddr_wr_valid <= wr_send;
            if (fill_start) begin
                fill_run <= 1'b1;
            end
            if (rd_take) begin
                if (cnt_inc == LAST) begin
                    cnt        <= '0;
                    fill_run   <= 1'b0;
                    burst_done <= 1'b1;
                end else begin
                    cnt <= cnt_inc;
                end
            end else if (wb_go) begin
                if (cnt == LAST) begin                 // last word is on the bus now.
                    cnt        <= '0;
                    wb_run     <= 1'b0;
                    burst_done <= 1'b1;
                end else begin
                    cnt    <= cnt_inc;
                    wb_run <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_send) begin
            ddr_wr_data <= lif.row_rdata;
        end
    end

endmodule

/* logic/cache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cmd_valid,
    input  cmd_t                        cmd,
    input  logic [`DC_ADDR_BITS-1:0]    addr,
    input  logic [`DC_COL_IDX_BITS-1:0] col,
    input  word_t                       row_wdata,
    input  col_t                        col_wdata,
    input  logic                        burst_done,
    output logic                        busy,
    output logic                        done,
    output word_t                       row_rdata,
    output col_t                        col_rdata,
    output logic                        fill_start,
    output logic                        wb_start,
    output logic [`DC_ADDR_BITS-1:0]    line_base,
    output logic [`DC_ADDR_BITS-1:0]    wb_base,
    line_if.ctrl_mp                     lif
);

    localparam int TAG_BITS = `DC_ADDR_BITS - `DC_ROW_IDX_BITS;

    ctrl_state_t                 state;
    cmd_t                        cmd_q;
    logic [`DC_ADDR_BITS-1:0]    addr_q;
    logic [`DC_COL_IDX_BITS-1:0] col_q;
    word_t                       row_wdata_q;
    col_t                        col_wdata_q;
    logic [TAG_BITS-1:0]         tag_q;
    logic                        valid_q;
    logic                        dirty_q;
    logic                        fill_kick;
    logic                        wb_kick;
    word_t                       row_rdata_q;
    col_t                        col_rdata_q;
    logic                        accept;
    logic                        hit;
    logic                        is_flush;
    logic                        is_store;
    logic                        wb_end;
    logic                        fill_end;
    logic                        access;

    assign accept   = cmd_valid && (state == ST_IDLE) && (cmd != CMD_NONE);
    assign hit      = valid_q && (tag_q == addr[`DC_ADDR_BITS-1 -: TAG_BITS]);
    assign is_flush = (cmd_q == CMD_FLUSH);
    assign is_store = (cmd_q == CMD_ROW_STORE) || (cmd_q == CMD_COL_STORE);
    assign wb_end   = (state == ST_WRITEBACK) && burst_done;
    assign fill_end = (state == ST_FILL) && burst_done;
    assign access   = (state == ST_ACCESS) || fill_end;  // the line is complete here.

    // ***********************************************************************
    // sequencing FSM
    // ***********************************************************************

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= ST_IDLE;
            valid_q   <= 1'b0;
            dirty_q   <= 1'b0;
            fill_kick <= 1'b0;
            wb_kick   <= 1'b0;
        end else begin
            fill_kick <= 1'b0;
            wb_kick   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        if (valid_q && dirty_q && ((cmd == CMD_FLUSH) || !hit)) begin
                            state   <= ST_WRITEBACK;
                            wb_kick <= 1'b1;
                        end else if ((cmd == CMD_FLUSH) || hit) begin
                            state <= ST_ACCESS;
                        end else begin
                            state     <= ST_FILL;
                            fill_kick <= 1'b1;
                        end
                    end
                end
                ST_WRITEBACK: begin
                    if (burst_done) begin
                        if (is_flush) begin
                            dirty_q <= 1'b0;
                            state   <= ST_IDLE;
                        end else begin
                            state <= ST_FILL;
                        end
                    end
                end
                ST_FILL: begin
                    if (burst_done) begin
                        valid_q <= 1'b1;
                        dirty_q <= is_store;   // a store completing the miss dirties the fresh line.
                        state   <= ST_IDLE;
                    end
                end
                ST_ACCESS: begin
                    if (is_store) begin
                        dirty_q <= 1'b1;
                    end
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q       <= cmd;
            addr_q      <= addr;
            col_q       <= col;
            row_wdata_q <= row_wdata;
            col_wdata_q <= col_wdata;
        end
        if (fill_end) begin
            tag_q <= addr_q[`DC_ADDR_BITS-1 -: TAG_BITS];
        end
        if (access) begin
            row_rdata_q <= lif.row_rdata;
            col_rdata_q <= lif.col_rdata;
        end
    end

    assign busy       = (state != ST_IDLE);
    assign done       = access || (wb_end && is_flush);
    assign wb_start   = wb_kick;
    assign fill_start = fill_kick || (wb_end && !is_flush);  // fill follows write-back at once.
    assign line_base  = {addr_q[`DC_ADDR_BITS-1 -: TAG_BITS], {`DC_ROW_IDX_BITS{1'b0}}};
    assign wb_base    = {tag_q, {`DC_ROW_IDX_BITS{1'b0}}};
    assign row_rdata  = access ? lif.row_rdata : row_rdata_q;
    assign col_rdata  = access ? lif.col_rdata : col_rdata_q;

    assign lif.engine_sel = (state == ST_WRITEBACK) || ((state == ST_FILL) && !burst_done);
    assign lif.row_idx    = addr_q[`DC_ROW_IDX_BITS-1:0];
    assign lif.row_wdata  = row_wdata_q;
    assign lif.row_we     = access && (cmd_q == CMD_ROW_STORE);
    assign lif.col_idx    = col_q;
    assign lif.col_wdata  = col_wdata_q;
    assign lif.col_we     = access && (cmd_q == CMD_COL_STORE);

endmodule

/* logic/data_cache_top.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module data_cache_top
    import cache_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cmd_valid,
    input  cmd_t                         cmd,
    input  logic [`DC_ADDR_BITS-1:0]     addr,
    input  logic [`DC_COL_IDX_BITS-1:0]  col,
    input  word_t                        row_wdata,
    input  col_t                         col_wdata,
    output logic                         busy,
    output logic                         done,
    output word_t                        row_rdata,
    output col_t                         col_rdata,
    output logic                         ddr_rd_req,
    output logic [`DC_DDR_ADDR_BITS-1:0] ddr_rd_addr,
    input  logic                         ddr_rd_valid,
    input  word_t                        ddr_rd_data,
    output logic                         ddr_wr_req,
    output logic [`DC_DDR_ADDR_BITS-1:0] ddr_wr_addr,
    output logic                         ddr_wr_valid,
    output word_t                        ddr_wr_data
);

    logic                     fill_start;
    logic                     wb_start;
    logic                     burst_done;
    logic [`DC_ADDR_BITS-1:0] line_base;
    logic [`DC_ADDR_BITS-1:0] wb_base;

    line_if lif ();

    cache_ctrl u_ctrl (
        .clk, .rst, .cmd_valid, .cmd, .addr, .col, .row_wdata, .col_wdata,
        .burst_done, .busy, .done, .row_rdata, .col_rdata,
        .fill_start, .wb_start, .line_base, .wb_base,
        .lif (lif.ctrl_mp)
    );

    ddr_burst_engine u_engine (
        .clk, .rst, .fill_start, .wb_start, .line_base, .wb_base,
        .ddr_rd_valid, .ddr_rd_data,
        .ddr_rd_req, .ddr_rd_addr, .ddr_wr_req, .ddr_wr_addr,
        .ddr_wr_valid, .ddr_wr_data, .burst_done,
        .lif (lif.engine_mp)
    );

    line_store u_store (
        .clk,
        .lif (lif.store_mp)
    );

endmodule

/* tests/cache_checker.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_checker
    import cache_pkg::*;
#(
    parameter int MEM_WORDS = 64
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cmd_valid,
    input  cmd_t                                 cmd,
    input  logic [`DC_ADDR_BITS-1:0]             addr,
    input  logic [`DC_COL_IDX_BITS-1:0]          col,
    input  word_t                                row_wdata,
    input  col_t                                 col_wdata,
    input  logic                                 busy,
    input  logic                                 done,
    input  word_t                                row_rdata,
    input  col_t                                 col_rdata,
    input  logic                                 ddr_rd_req,
    input  logic [`DC_DDR_ADDR_BITS-1:0]         ddr_rd_addr,
    input  logic                                 ddr_rd_valid,
    input  logic                                 ddr_wr_req,
    input  logic [`DC_DDR_ADDR_BITS-1:0]         ddr_wr_addr,
    input  logic                                 ddr_wr_valid,
    input  word_t                                ddr_wr_data,
    input  logic [MEM_WORDS*`DC_WORD_BITS-1:0]   init_image,
    input  logic                                 run_end,
    output int                                   err_count,
    output int                                   test_count
);

    localparam int LW = `DC_LINE_WORDS;

    word_t ref_mem [MEM_WORDS];   // what memory should hold after every finished command.
    word_t ddr_seen [MEM_WORDS];  // what the DUT actually wrote back.
    int    cyc, acc_cyc, last_wr_cyc, last_rd_cyc, wr_count, rd_count, err_at_start;
    int    m_line, p_line, wb_line;
    logic  m_valid, m_dirty, pend, exp_wb, exp_fill, wb_seen;
    cmd_t  p_cmd;
    logic [`DC_ADDR_BITS-1:0]    p_addr;
    logic [`DC_COL_IDX_BITS-1:0] p_col;
    word_t p_row_wdata;
    col_t  p_col_wdata;

    task automatic fail(input string msg);
        $display("Fail %0t: %s", $time, msg);
        err_count++;
    endtask

    function automatic logic [`DC_DDR_ADDR_BITS-1:0] byte_addr(input int line);
        return `DC_DDR_ADDR_BITS'(line * LW) << `DC_DDR_ADDR_SHIFT;
    endfunction

    // ***********************************************************************
    // command start and end
    // ***********************************************************************

    task automatic start_cmd();
        logic hit;
        p_cmd        = cmd;
        p_addr       = addr;
        p_col        = col;
        p_row_wdata  = row_wdata;
        p_col_wdata  = col_wdata;
        p_line       = int'(addr) / LW;
        hit          = m_valid && (m_line == p_line);
        exp_wb       = m_valid && m_dirty && ((cmd == CMD_FLUSH) || !hit);
        exp_fill     = (cmd != CMD_FLUSH) && !hit;
        wb_line      = m_line;
        acc_cyc      = cyc;
        wr_count     = 0;
        rd_count     = 0;
        wb_seen      = 1'b0;
        err_at_start = err_count;
        pend         = 1'b1;
    endtask

    task automatic finish_cmd();
        int   base;
        col_t exp_c;
        base = p_line * LW;
        if (exp_fill) begin
            if (rd_count != LW || cyc != last_rd_cyc + 1)
                fail($sformatf("done out of step with fill, %0d words", rd_count));
        end else if (exp_wb) begin
            if (wr_count != LW || cyc != last_wr_cyc + 1)
                fail($sformatf("done out of step with write-back, %0d words", wr_count));
        end else if (cyc != acc_cyc + 1) begin
            fail($sformatf("done %0d cycles after command, expected 1", cyc - acc_cyc));
        end
        for (int i = 0; i < LW; i++) begin
            exp_c[i] = ref_mem[base + i][p_col];
        end
        case (p_cmd)
            CMD_ROW_LOAD: if (row_rdata !== ref_mem[base + int'(p_addr) % LW])
                fail($sformatf("row load %h got %h expected %h", p_addr, row_rdata,
                               ref_mem[base + int'(p_addr) % LW]));
            CMD_COL_LOAD: if (col_rdata !== exp_c)
                fail($sformatf("column load line %0d col %0d got %h expected %h",
                               p_line, p_col, col_rdata, exp_c));
            CMD_ROW_STORE: ref_mem[base + int'(p_addr) % LW] = p_row_wdata;
            CMD_COL_STORE: for (int i = 0; i < LW; i++) begin
                ref_mem[base + i][p_col] = p_col_wdata[i];
            end
            default: ;
        endcase
        if (exp_fill) begin
            m_valid = 1'b1;
            m_line  = p_line;
            m_dirty = 1'b0;
        end
        if (p_cmd == CMD_FLUSH) m_dirty = 1'b0;
        if (p_cmd == CMD_ROW_STORE || p_cmd == CMD_COL_STORE) m_dirty = 1'b1;
        test_count++;
        $display("test %0d %s addr %h: %s", test_count, p_cmd.name(), p_addr,
                 (err_count == err_at_start) ? "ok" : "mismatch");
        pend = 1'b0;
    endtask

    // ***********************************************************************
    // per-cycle monitor
    // ***********************************************************************

    always @(posedge clk) begin
        cyc++;
        if (!rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                ref_mem[i]  = init_image[i*`DC_WORD_BITS +: `DC_WORD_BITS];
                ddr_seen[i] = init_image[i*`DC_WORD_BITS +: `DC_WORD_BITS];
            end
            m_valid = 1'b0;   // the line starts out empty.
            m_dirty = 1'b0;
            m_line  = -1;
            pend    = 1'b0;
        end else if (pend) begin
            if (!busy) fail("busy low while a command is in progress");
            if (ddr_wr_req) begin
                wb_seen = 1'b1;
                if (!exp_wb) fail("write burst started on a clean or held line");
                if (cyc != acc_cyc + 1) fail("write request not 1 cycle after command");
                if (ddr_wr_addr !== byte_addr(wb_line))
                    fail($sformatf("write address %h expected %h", ddr_wr_addr,
                                   byte_addr(wb_line)));
            end
            if (ddr_wr_valid) begin
                if (!wb_seen || wr_count >= LW) begin
                    fail("write data outside a write burst");
                end else begin
                    if (wr_count > 0 && cyc != last_wr_cyc + 1) fail("gap in write burst");
                    if (ddr_wr_data !== ref_mem[wb_line*LW + wr_count])
                        fail($sformatf("write-back word %0d got %h expected %h", wr_count,
                                       ddr_wr_data, ref_mem[wb_line*LW + wr_count]));
                    ddr_seen[wb_line*LW + wr_count] = ddr_wr_data;
                end
                wr_count++;
                last_wr_cyc = cyc;
            end
            if (ddr_rd_req) begin
                if (!exp_fill) fail("fill requested on a hit or flush");
                if (exp_wb && (wr_count != LW || cyc != last_wr_cyc + 1))
                    fail("fill request not 1 cycle after the write burst");
                if (!exp_wb && cyc != acc_cyc + 1) fail("fill request not 1 cycle after command");
                if (ddr_rd_addr !== byte_addr(p_line))
                    fail($sformatf("fill address %h expected %h", ddr_rd_addr,
                                   byte_addr(p_line)));
            end
            if (ddr_rd_valid) begin
                rd_count++;
                last_rd_cyc = cyc;
            end
            if (done) finish_cmd();
        end else begin
            if (busy || done || ddr_rd_req || ddr_wr_req || ddr_wr_valid || ddr_rd_valid)
                fail("busy, done or a DDR strobe high with no command in progress");
        end
        if (rst && cmd_valid && !busy && cmd != CMD_NONE) start_cmd();
        if (rst && run_end) begin
            err_at_start = err_count;
            for (int i = 0; i < MEM_WORDS; i++) begin
                if (ddr_seen[i] !== ref_mem[i])
                    fail($sformatf("DDR word %0d holds %h expected %h", i, ddr_seen[i],
                                   ref_mem[i]));
            end
            test_count++;
            $display("test %0d final DDR compare: %s", test_count,
                     (err_count == err_at_start) ? "ok" : "mismatch");
        end
    end

    initial begin
        err_count  = 0;
        test_count = 0;
        cyc        = 0;
        pend       = 1'b0;
    end

endmodule

/* tests/tb_data_cache.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module tb_data_cache
    import cache_pkg::*;
();

    localparam int          N_CMDS      = 300;
    localparam int          CYC_PER_CMD = 60;
    localparam int          TIMEOUT     = (N_CMDS + 1) * CYC_PER_CMD;
    localparam int          MEM_WORDS   = 64;
    localparam logic [31:0] SEED        = 32'h39b2a24c;

    logic clk, rst, cmd_valid, busy, done;
    cmd_t cmd;
    logic [`DC_ADDR_BITS-1:0]     addr;
    logic [`DC_COL_IDX_BITS-1:0]  col;
    word_t row_wdata, row_rdata, ddr_rd_data, ddr_wr_data;
    col_t  col_wdata, col_rdata;
    logic  ddr_rd_req, ddr_rd_valid, ddr_wr_req, ddr_wr_valid;
    logic [`DC_DDR_ADDR_BITS-1:0] ddr_rd_addr, ddr_wr_addr;

    word_t ddr_mem [MEM_WORDS];
    logic [MEM_WORDS*`DC_WORD_BITS-1:0] init_image;
    logic  run_end;
    int    err_count, test_count, cycles;
    logic [31:0] stim_lfsr, gap_lfsr;
    logic  rd_active;
    int    rd_base, rd_cnt, wr_base, wr_cnt;

    data_cache_top i_dut (.*);

    cache_checker #(.MEM_WORDS(MEM_WORDS)) i_checker (.*);

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(inout logic [31:0] s, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = {v[30:0], s[0]};
        end
    endtask

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    end

    // ***********************************************************************
    // DDR model
    // ***********************************************************************

    always @(posedge clk) begin : ddr_model
        logic [31:0] g;
        if (ddr_wr_req) begin
            wr_base = int'(ddr_wr_addr >> `DC_DDR_ADDR_SHIFT) % MEM_WORDS;
            wr_cnt  = 0;
        end
        if (ddr_wr_valid) begin
            ddr_mem[(wr_base + wr_cnt) % MEM_WORDS] = ddr_wr_data;
            wr_cnt++;
        end
        if (ddr_rd_req) begin
            rd_base   = int'(ddr_rd_addr >> `DC_DDR_ADDR_SHIFT) % MEM_WORDS;
            rd_cnt    = 0;
            rd_active = 1'b1;
        end
        ddr_rd_valid <= 1'b0;
        if (rd_active) begin
            take_bits(gap_lfsr, 1, g);
            if (g[0]) begin                  // about half the cycles carry a word.
                ddr_rd_valid <= 1'b1;
                ddr_rd_data  <= ddr_mem[(rd_base + rd_cnt) % MEM_WORDS];
                rd_cnt++;
                if (rd_cnt == `DC_LINE_WORDS) rd_active = 1'b0;
            end
        end
    end

    task automatic issue_cmd(input cmd_t c, input logic [`DC_ADDR_BITS-1:0] a,
                             input logic [`DC_COL_IDX_BITS-1:0] cl, input word_t rw,
                             input col_t cw);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        addr      <= a;
        col       <= cl;
        row_wdata <= rw;
        col_wdata <= cw;
        @(posedge clk);
        cmd_valid <= 1'b0;
        @(posedge clk);
        while (!done) @(posedge clk);
    endtask

    task automatic random_cmd();
        logic [31:0] r, a, cl, rw, cw;
        cmd_t c;
        take_bits(stim_lfsr, 3, r);
        case (r[2:0])
            3'd0, 3'd4: c = CMD_ROW_LOAD;
            3'd1, 3'd6: c = CMD_ROW_STORE;
            3'd2, 3'd5: c = CMD_COL_LOAD;
            3'd3:       c = CMD_COL_STORE;
            default:    c = CMD_FLUSH;
        endcase
        take_bits(stim_lfsr, 6, a);      // four lines only, so misses stay frequent.
        take_bits(stim_lfsr, `DC_COL_IDX_BITS, cl);
        take_bits(stim_lfsr, `DC_WORD_BITS, rw);
        take_bits(stim_lfsr, `DC_LINE_WORDS, cw);
        issue_cmd(c, a[`DC_ADDR_BITS-1:0], cl[`DC_COL_IDX_BITS-1:0], rw[`DC_WORD_BITS-1:0],
                  cw[`DC_LINE_WORDS-1:0]);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        rst          = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = CMD_NONE;
        addr         = '0;
        col          = '0;
        row_wdata    = '0;
        col_wdata    = '0;
        ddr_rd_valid = 1'b0;
        ddr_rd_data  = '0;
        run_end      = 1'b0;
        cycles       = 0;
        rd_active    = 1'b0;
        stim_lfsr    = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            take_bits(stim_lfsr, `DC_WORD_BITS, r);
            ddr_mem[i] = r[`DC_WORD_BITS-1:0];
            init_image[i*`DC_WORD_BITS +: `DC_WORD_BITS] = r[`DC_WORD_BITS-1:0];
        end
        gap_lfsr = stim_lfsr;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        for (int n = 0; n < N_CMDS; n++) begin
            random_cmd();
        end
        issue_cmd(CMD_FLUSH, '0, '0, '0, '0);
        @(posedge clk);
        run_end <= 1'b1;
        @(posedge clk);
        run_end <= 1'b0;
        repeat (2) @(posedge clk);
        $display("tests run %0d, errors %0d", test_count, err_count);
        if (err_count == 0 && test_count == N_CMDS + 2) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* data_cache.f */
+incdir+logic
logic/cache_pkg.sv
logic/line_if.sv
logic/line_store.sv
logic/ddr_burst_engine.sv
logic/cache_ctrl.sv
logic/data_cache_top.sv
tests/cache_checker.sv
tests/tb_data_cache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the data cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_data_cache \
    -f data_cache.f -Mdir obj_dir -o sim_data_cache > compile.log 2>&1
if [ $? -ne 0 ]; then
    cat compile.log
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_data_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation step returned status $status"
    exit 1
fi

if grep -qxF '** PASS **' sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
